// ==== hdl/touch_proto_pkg.sv ====
package touch_proto_pkg;

	// Converter channel select codes, as sent in command bits 2:1
	typedef enum logic [1:0] {
		CH_Y = 2'b00, // Y plate
		CH_Z = 2'b01, // Pressure
		CH_X = 2'b10  // X plate
	} channel_e;

	// Command byte layout, sent bit 0 first
	localparam int CMD_BITS      = 8; // Command length in serial periods
	localparam int CMD_START_BIT = 0; // Always 1, first bit on the wire
	localparam int CMD_CH_LSB    = 1; // Channel code in bits 2:1
	localparam int CMD_MODE_BIT  = 3; // Always 1
	// Bits 7:4 stay 0, so the line is already low by the end of the command

	// Conversion result returned by the converter, MSB first
	localparam int RESULT_BITS = 12;

	// Frame layout, counted in serial clock periods from the frame start
	localparam int CMD_FIRST  = 0;  // First command bit
	localparam int CMD_LAST   = 7;  // Last command bit
	localparam int BUSY_POS   = 8;  // Converter busy, nothing on the wire
	localparam int READ_FIRST = 9;  // First result bit sampled here
	localparam int READ_LAST  = 20; // Last result bit sampled here
	localparam int FRAME_LAST = 24; // End of the idle tail

	// Whole frame is FRAME_LAST + 1 periods
	// Result window must hold the full result word
	// READ_LAST - READ_FIRST + 1 == RESULT_BITS

endpackage

// ==== hdl/touch_result_regs.sv ====
`timescale 1ns/1ps

module touch_result_regs (
	input  logic                                    cclk,
	input  logic                                    rstb,
	input  logic                                    capture, // Last frame of a channel done
	input  touch_proto_pkg::channel_e               channel, // Already moved to the next channel
	input  logic [touch_proto_pkg::RESULT_BITS-1:0] rx_word,
	output logic [touch_proto_pkg::RESULT_BITS-1:0] x,
	output logic [touch_proto_pkg::RESULT_BITS-1:0] y,
	output logic [touch_proto_pkg::RESULT_BITS-1:0] z
);

	logic load_x; // Per register load enables
	logic load_y;
	logic load_z;

	// The sequencer rotates the channel together with capture
	// so the channel being left is the one before the current one
	always_comb begin
		load_x = 1'b0;
		load_y = 1'b0;
		load_z = 1'b0;
		if (capture) begin
			case (channel)
				touch_proto_pkg::CH_Y: load_x = 1'b1; // Left X
				touch_proto_pkg::CH_Z: load_y = 1'b1; // Left Y
				default:               load_z = 1'b1; // Left Z, back on X
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			x <= '0;
			y <= '0;
			z <= '0;
		end else begin
			if (load_x)
				x <= rx_word;
			if (load_y)
				y <= rx_word;
			if (load_z)
				z <= rx_word; // Values hold between captures
		end
	end

	// rx_word still holds the last frame here
	// The clear at frame_start lands on the same edge as this load

endmodule

// ==== hdl/touch_sclk_gen.sv ====
`timescale 1ns/1ps

module touch_sclk_gen (
	input  logic cclk,
	input  logic rstb,
	output logic touch_clk, // Serial clock to the converter
	output logic sclk_rise, // One cclk pulse, touch_clk just went high
	output logic sclk_fall  // One cclk pulse, touch_clk just went low
);

	// Divider count within one half period
	logic [$clog2(touch_timing_pkg::SCLK_HALF_COUNT)-1:0] div_cnt;

	// Half period end, toggle point
	logic half_done;

	assign half_done = (int'(div_cnt) == touch_timing_pkg::SCLK_HALF_COUNT - 1);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			div_cnt   <= '0;
			touch_clk <= 1'b0; // Idle low, first edge is a rise
			sclk_rise <= 1'b0;
			sclk_fall <= 1'b0;
		end else begin
			sclk_rise <= 1'b0; // Strobes last one cycle
			sclk_fall <= 1'b0;
			if (half_done) begin
				div_cnt   <= '0;
				touch_clk <= ~touch_clk;
				// Strobe matches the direction of this toggle
				sclk_rise <= ~touch_clk;
				sclk_fall <= touch_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Strobes land in the same cycle that touch_clk changes
	// First rise comes SCLK_HALF_COUNT cycles after reset release

endmodule

// ==== hdl/touch_sequencer.sv ====
`timescale 1ns/1ps

module touch_sequencer (
	input  logic                      cclk,
	input  logic                      rstb,
	input  logic                      sclk_rise,
	input  logic                      sclk_fall,
	output logic                      frame_start, // Period 0 begins
	output logic                      tx_shift,    // Periods 1..7 begin
	output logic                      rx_sample,   // Rise inside periods 9..20
	output logic                      capture,     // Frame 15 of a channel ended
	output touch_proto_pkg::channel_e channel      // Channel of the current frame
);

	logic [touch_timing_pkg::POS_W-1:0] pos; // Period that the next falling edge starts
	logic [touch_timing_pkg::REP_W-1:0] rep; // Frames on this channel that reached the tail

	touch_timing_pkg::seq_state_e state;       // Phase of the running period
	touch_timing_pkg::seq_state_e start_state; // Phase of the period about to start

	// Frame phase for a given period number
	function automatic touch_timing_pkg::seq_state_e phase_of(input int p);
		if (p <= touch_proto_pkg::CMD_LAST)
			phase_of = touch_timing_pkg::ST_CMD;
		else if (p == touch_proto_pkg::BUSY_POS)
			phase_of = touch_timing_pkg::ST_BUSY;
		else if (p >= touch_proto_pkg::READ_FIRST && p <= touch_proto_pkg::READ_LAST)
			phase_of = touch_timing_pkg::ST_READ;
		else
			phase_of = touch_timing_pkg::ST_GAP;
	endfunction

	// Channel visiting order X, Y, Z
	function automatic touch_proto_pkg::channel_e next_channel(
		input touch_proto_pkg::channel_e ch
	);
		case (ch)
			touch_proto_pkg::CH_X: next_channel = touch_proto_pkg::CH_Y;
			touch_proto_pkg::CH_Y: next_channel = touch_proto_pkg::CH_Z;
			default:               next_channel = touch_proto_pkg::CH_X;
		endcase
	endfunction

	always_comb begin
		start_state = phase_of(int'(pos));
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pos         <= '0;
			rep         <= '0;
			state       <= touch_timing_pkg::ST_CMD;
			channel     <= touch_proto_pkg::CH_X; // Sweep always starts on X
			frame_start <= 1'b0;
			tx_shift    <= 1'b0;
			rx_sample   <= 1'b0;
			capture     <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			tx_shift    <= 1'b0;
			rx_sample   <= 1'b0;
			capture     <= 1'b0;

			if (sclk_fall) begin
				state <= start_state; // New period begins on the falling edge
				frame_start <= (start_state == touch_timing_pkg::ST_CMD) &&
					(int'(pos) == touch_proto_pkg::CMD_FIRST);
				tx_shift <= (start_state == touch_timing_pkg::ST_CMD) &&
					(int'(pos) != touch_proto_pkg::CMD_FIRST);

				if (int'(pos) == touch_proto_pkg::FRAME_LAST) begin
					pos <= '0;
					rep <= rep + 1'b1; // Frame reached its tail
				end else begin
					pos <= pos + 1'b1;
				end

				// Edge that ends the last frame of a channel
				if (int'(pos) == touch_proto_pkg::CMD_FIRST &&
					int'(rep) == touch_timing_pkg::FRAMES_PER_CHANNEL) begin
					capture <= 1'b1;
					rep     <= '0;
					channel <= next_channel(channel); // New frame_start sees the new channel
				end
			end

			if (sclk_rise)
				rx_sample <= (state == touch_timing_pkg::ST_READ); // Converter data stable on rise
		end
	end

endmodule

// ==== hdl/touch_shifter.sv ====
`timescale 1ns/1ps

module touch_shifter (
	input  logic                                  cclk,
	input  logic                                  rstb,
	input  logic                                  frame_start, // Load command, present bit 0
	input  logic                                  tx_shift,    // Present the next command bit
	input  logic                                  rx_sample,   // Take one result bit
	input  logic                                  data_in,     // Serial data from the converter
	input  touch_proto_pkg::channel_e             channel,
	output logic                                  data_out,    // Serial data to the converter
	output logic [touch_proto_pkg::RESULT_BITS-1:0] rx_word
);

	logic [touch_proto_pkg::CMD_BITS-1:0] cmd;    // Command for the current channel
	logic [touch_proto_pkg::CMD_BITS-1:0] tx_reg; // Bits not yet on the wire

	// Command byte from the channel code
	always_comb begin
		cmd = '0; // Upper nibble stays clear
		cmd[touch_proto_pkg::CMD_START_BIT] = 1'b1;
		cmd[touch_proto_pkg::CMD_MODE_BIT]  = 1'b1;
		cmd[touch_proto_pkg::CMD_CH_LSB +: 2] = channel;
	end

	// Transmit side, LSB first
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			data_out <= 1'b0;
		end else if (frame_start) begin
			data_out <= cmd[0];
		end else if (tx_shift) begin
			data_out <= tx_reg[0];
		end
	end

	// Remaining command bits, zero filled from the top
	always_ff @(posedge cclk) begin
		if (frame_start)
			tx_reg <= cmd >> 1;
		else if (tx_shift)
			tx_reg <= tx_reg >> 1;
	end

	// data_out is low from period 4 on since bits 7:4 are zero
	// It stays low through busy, read and gap until the next frame

	// Receive side, MSB first, new bits enter at the bottom
	always_ff @(posedge cclk) begin
		if (frame_start)
			rx_word <= '0; // Fresh word each frame
		else if (rx_sample)
			rx_word <= {rx_word[touch_proto_pkg::RESULT_BITS-2:0], data_in};
	end

	// After 12 samples the first bit received sits in bit 11

endmodule

// ==== hdl/touch_timing_pkg.sv ====
package touch_timing_pkg;

	// Serial clock divider
	localparam int SCLK_HALF_COUNT = 100; // cclk cycles per half period of touch_clk

	// Repeated frames per channel, only the last result is kept
	localparam int FRAMES_PER_CHANNEL = 15;

	// Counter widths
	localparam int POS_W = 5; // Holds frame positions 0..24
	localparam int REP_W = 4; // Holds repetition counts 0..15

	// Sequencer phase within a frame
	typedef enum logic [1:0] {
		ST_CMD,  // Command bits going out
		ST_BUSY, // Converter busy period
		ST_READ, // Result bits coming in
		ST_GAP   // Idle tail of the frame
	} seq_state_e;

	// Phase order inside a frame
	// ST_CMD -> ST_BUSY -> ST_READ -> ST_GAP -> ST_CMD

endpackage

// ==== hdl/touchpad_controller.sv ====
`timescale 1ns/1ps

module touchpad_controller (
	input  logic                                    cclk,
	input  logic                                    rstb,
	input  logic                                    data_in,   // From converter
	output logic                                    touch_clk, // Serial clock
	output logic                                    data_out,  // To converter
	output logic                                    touch_csb, // Chip select, active low
	output logic [touch_proto_pkg::RESULT_BITS-1:0] x,
	output logic [touch_proto_pkg::RESULT_BITS-1:0] y,
	output logic [touch_proto_pkg::RESULT_BITS-1:0] z
);

	logic sclk_rise;   // Serial edge strobes
	logic sclk_fall;
	logic frame_start; // Sequencer strobes
	logic tx_shift;
	logic rx_sample;
	logic capture;

	touch_proto_pkg::channel_e                channel; // Current frame channel
	logic [touch_proto_pkg::RESULT_BITS-1:0] rx_word; // Last received result

	// Chip select held low whenever out of reset
	always_ff @(posedge cclk) begin
		if (!rstb)
			touch_csb <= 1'b1;
		else
			touch_csb <= 1'b0;
	end

	touch_sclk_gen sclk_gen_i (
		.cclk      (cclk),
		.rstb      (rstb),
		.touch_clk (touch_clk),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall)
	);

	touch_sequencer sequencer_i (
		.cclk        (cclk),
		.rstb        (rstb),
		.sclk_rise   (sclk_rise),
		.sclk_fall   (sclk_fall),
		.frame_start (frame_start),
		.tx_shift    (tx_shift),
		.rx_sample   (rx_sample),
		.capture     (capture),
		.channel     (channel)
	);

	touch_shifter shifter_i (
		.cclk        (cclk),
		.rstb        (rstb),
		.frame_start (frame_start),
		.tx_shift    (tx_shift),
		.rx_sample   (rx_sample),
		.data_in     (data_in),
		.channel     (channel),
		.data_out    (data_out),
		.rx_word     (rx_word)
	);

	touch_result_regs result_regs_i (
		.cclk    (cclk),
		.rstb    (rstb),
		.capture (capture),
		.channel (channel),
		.rx_word (rx_word),
		.x       (x),
		.y       (y),
		.z       (z)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the touchpad controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	-f touchpad_controller.f \
	--top-module touchpad_controller_tb \
	-o touchpad_sim
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/touchpad_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"
if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi

// ==== testbench/touch_adc_model.sv ====
`timescale 1ns/1ps

module touch_adc_model (
	input  logic        cclk,
	input  logic        touch_clk,
	input  logic        touch_csb,
	input  logic        data_out,   // Command bits from the controller
	output logic        data_in,    // Result bits to the controller
	output logic        cmd_strobe, // One cclk pulse per decoded command
	output logic [7:0]  cmd_byte,   // Last decoded command
	output logic [11:0] exp_x,      // Reply of the 15th frame of each channel
	output logic [11:0] exp_y,
	output logic [11:0] exp_z
);

	integer seed = 33; // Fixed seed for the replies

	logic        din_q = 1'b0;
	logic        strobe_q = 1'b0;
	logic [7:0]  byte_q = 8'h00;
	logic [11:0] ex_q = 12'h000;
	logic [11:0] ey_q = 12'h000;
	logic [11:0] ez_q = 12'h000;
	logic        prev_clk = 1'b0; // touch_clk seen at the previous cclk edge
	logic        started = 1'b0;  // A frame is running
	int          p = 0;           // Serial period inside the frame
	int          np;
	int          run;
	int          cur_run = 0;     // Frames in a row on the current channel
	logic [1:0]  cur_ch = 2'b00;
	logic        have_ch = 1'b0;
	logic [7:0]  cmd_sr = 8'h00;  // Command bits caught so far
	logic [7:0]  full;
	logic [31:0] r;
	logic [11:0] reply = 12'h000; // Reply of the running frame

	assign data_in    = din_q;
	assign cmd_strobe = strobe_q;
	assign cmd_byte   = byte_q;
	assign exp_x      = ex_q;
	assign exp_y      = ey_q;
	assign exp_z      = ez_q;

	always @(posedge cclk) begin
		strobe_q <= 1'b0;
		prev_clk <= touch_clk;
		if (touch_csb) begin
			started <= 1'b0; // Deselected, forget the frame
			have_ch <= 1'b0;
			din_q   <= 1'b0;
		end else if (prev_clk && !touch_clk) begin
			np = (!started || p == 24) ? 0 : p + 1; // Falling edge opens a period
			started <= 1'b1;
			p       <= np;
			if (np == 9) begin
				r = $random(seed); // New reply, MSB goes out first
				reply <= r[11:0];
				din_q <= r[11];
				if (cur_run == 15) begin
					case (cur_ch)
						touch_proto_pkg::CH_X: ex_q <= r[11:0];
						touch_proto_pkg::CH_Y: ey_q <= r[11:0];
						default:               ez_q <= r[11:0];
					endcase
				end
			end else if (np >= 10 && np <= 20) begin
				din_q <= reply[4'(20 - np)];
			end else begin
				din_q <= 1'b0; // Line idles low outside the result
			end
		end else if (!prev_clk && touch_clk && started && p <= 7) begin
			full = cmd_sr;
			full[p[2:0]] = data_out; // Bit 0 comes first
			cmd_sr <= full;
			if (p == 7) begin
				run = (have_ch && full[2:1] == cur_ch) ? cur_run + 1 : 1;
				cur_run  <= run;
				cur_ch   <= full[2:1];
				have_ch  <= 1'b1;
				byte_q   <= full;
				strobe_q <= 1'b1;
			end
		end
	end

endmodule

// ==== testbench/touchpad_controller_tb.sv ====
`timescale 1ns/1ps

module touchpad_controller_tb;

	logic        cclk;
	logic        rstb;
	logic        data_in;
	logic        touch_clk;
	logic        data_out;
	logic        touch_csb;
	logic [11:0] x;
	logic [11:0] y;
	logic [11:0] z;
	logic        cmd_strobe;
	logic [7:0]  cmd_byte;
	logic [11:0] exp_x;
	logic [11:0] exp_y;
	logic [11:0] exp_z;

	int error_count = 0;
	int test_errs = 0;     // Error count when the running test began
	int tests_run = 0;
	int tests_failed = 0;
	int cmd_count = 0;     // Commands since reset release
	int x_changes = 0;
	int y_changes = 0;
	int z_changes = 0;
	logic [11:0] prev_x = 12'h000;
	logic [11:0] prev_y = 12'h000;
	logic [11:0] prev_z = 12'h000;

	touchpad_controller touchpad_controller_i (
		.cclk      (cclk),
		.rstb      (rstb),
		.data_in   (data_in),
		.touch_clk (touch_clk),
		.data_out  (data_out),
		.touch_csb (touch_csb),
		.x         (x),
		.y         (y),
		.z         (z)
	);

	touch_adc_model adc_i (
		.cclk       (cclk),
		.touch_clk  (touch_clk),
		.touch_csb  (touch_csb),
		.data_out   (data_out),
		.data_in    (data_in),
		.cmd_strobe (cmd_strobe),
		.cmd_byte   (cmd_byte),
		.exp_x      (exp_x),
		.exp_y      (exp_y),
		.exp_z      (exp_z)
	);

	initial begin
		cclk = 1'b0;
		forever #10 cclk = ~cclk; // 20 ns period
	end

	task report_error(input string msg);
		error_count++;
		$display("** Error at %0d ns: %s", $time, msg);
	endtask

	task timeout_abort(input string what);
		error_count++;
		$display("Timeout: %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task finish_test(input string name);
		tests_run++;
		if (error_count != test_errs) begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - test_errs);
		end else begin
			$display("Test %s: passed", name);
		end
		test_errs = error_count;
	endtask

	// X, Y, Z in blocks of 15 commands
	function automatic logic [1:0] expected_channel(input int n);
		case ((n / 15) % 3)
			0:       expected_channel = touch_proto_pkg::CH_X;
			1:       expected_channel = touch_proto_pkg::CH_Y;
			default: expected_channel = touch_proto_pkg::CH_Z;
		endcase
	endfunction

	task check_reset_outputs;
		assert (touch_csb == 1'b1) else report_error("touch_csb not high in reset");
		assert (touch_clk == 1'b0) else report_error("touch_clk not low in reset");
		assert (data_out == 1'b0) else report_error("data_out not low in reset");
		assert (x == 12'h000 && y == 12'h000 && z == 12'h000)
			else report_error($sformatf("results not clear, x %h y %h z %h", x, y, z));
	endtask

	task wait_commands(input int n);
		int cnt;
		cnt = 0;
		while (cmd_count < n && cnt < 120000) begin
			@(negedge cclk);
			cnt++;
		end
		if (cmd_count < n)
			timeout_abort($sformatf("command %0d never arrived", n));
	endtask

	task wait_sclk_change(output int cycles);
		logic level;
		level  = touch_clk;
		cycles = 0;
		while (touch_clk == level && cycles < 300) begin
			@(negedge cclk);
			cycles++;
		end
		if (touch_clk == level)
			timeout_abort("touch_clk stopped toggling");
	endtask

	// Start bit of the next command, within one frame
	task wait_data_out_high;
		int cycles;
		cycles = 0;
		while (data_out == 1'b0 && cycles < 6000) begin
			@(negedge cclk);
			cycles++;
		end
		if (data_out == 1'b0)
			timeout_abort("data_out never went high");
	endtask

	task check_register(input string name, input logic [11:0] value,
		input logic [11:0] expected, input int changes, input int expected_changes);
		assert (value == expected)
			else report_error($sformatf("%s is %h, expected %h", name, value, expected));
		assert (changes == expected_changes)
			else report_error($sformatf("%s changed %0d times, expected %0d", name,
				changes, expected_changes));
	endtask

	// Command checks, counted per reset
	always @(posedge cclk) begin
		if (!rstb) begin
			cmd_count <= 0;
		end else if (cmd_strobe) begin
			assert (cmd_byte[0] && cmd_byte[3] && cmd_byte[7:4] == 4'h0)
				else report_error($sformatf("bad command byte %h", cmd_byte));
			assert (cmd_byte[2:1] == expected_channel(cmd_count))
				else report_error($sformatf("command %0d channel %b, expected %b",
					cmd_count, cmd_byte[2:1], expected_channel(cmd_count)));
			cmd_count <= cmd_count + 1;
		end
	end

	// Count register updates
	always @(negedge cclk) begin
		if (!rstb) begin
			x_changes <= 0;
			y_changes <= 0;
			z_changes <= 0;
		end else begin
			if (x != prev_x) x_changes <= x_changes + 1;
			if (y != prev_y) y_changes <= y_changes + 1;
			if (z != prev_z) z_changes <= z_changes + 1;
		end
		prev_x <= x;
		prev_y <= y;
		prev_z <= z;
	end

	initial begin
		int cnt;
		int csb_low_at;
		int half;
		logic [11:0] old_x;
		logic [11:0] old_y;
		logic [11:0] old_z;
		rstb = 1'b0;
		repeat (4) begin // 4 reset cycles
			@(negedge cclk);
			check_reset_outputs();
		end
		@(posedge cclk);
		rstb <= 1'b1;
		cnt = 0;
		csb_low_at = 0;
		while (touch_clk == 1'b0 && cnt < 300) begin
			@(negedge cclk);
			cnt++;
			if (touch_csb == 1'b0 && csb_low_at == 0)
				csb_low_at = cnt;
		end
		if (touch_clk == 1'b0)
			timeout_abort("touch_clk never rose after reset");
		assert (csb_low_at == 2)
			else report_error($sformatf("touch_csb low after %0d cycles", csb_low_at));
		finish_test("reset state");

		// Count starts at the negedge after the release edge
		assert (cnt == 101) else report_error($sformatf("first rise after %0d cycles", cnt - 1));
		repeat (6) begin
			wait_sclk_change(half);
			assert (half == 100) else report_error($sformatf("half period %0d cycles", half));
		end
		finish_test("serial clock");

		wait_commands(16); // First Y command, x loaded
		check_register("x", x, exp_x, x_changes, 1);
		assert (y_changes == 0 && z_changes == 0) else report_error("y or z changed early");
		wait_commands(31);
		check_register("y", y, exp_y, y_changes, 1);
		assert (z_changes == 0) else report_error("z changed early");
		wait_commands(46); // Back on X
		check_register("z", z, exp_z, z_changes, 1);
		finish_test("command sequence");
		check_register("x", x, exp_x, x_changes, 1);
		finish_test("captured values");

		old_x = x;
		old_y = y;
		old_z = z;
		wait_commands(61);
		check_register("x", x, exp_x, x_changes, (exp_x != old_x) ? 2 : 1);
		wait_commands(76);
		check_register("y", y, exp_y, y_changes, (exp_y != old_y) ? 2 : 1);
		wait_commands(91);
		check_register("z", z, exp_z, z_changes, (exp_z != old_z) ? 2 : 1);
		finish_test("hold and second sweep");

		wait_commands(107); // Inside the Y frames of the third sweep
		wait_data_out_high(); // Start bit of the next Y command
		wait_sclk_change(half); // Rise in period 0, touch_clk and data_out both high
		@(posedge cclk);
		rstb <= 1'b0;
		@(negedge cclk);
		repeat (4) begin
			@(negedge cclk);
			check_reset_outputs();
		end
		@(posedge cclk);
		rstb <= 1'b1;
		wait_commands(1);
		assert (cmd_byte[2:1] == touch_proto_pkg::CH_X)
			else report_error($sformatf("first command after reset on %b", cmd_byte[2:1]));
		finish_test("reset mid-frame");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== touchpad_controller.f ====
hdl/touch_proto_pkg.sv
hdl/touch_timing_pkg.sv
hdl/touch_sclk_gen.sv
hdl/touch_sequencer.sv
hdl/touch_shifter.sv
hdl/touch_result_regs.sv
hdl/touchpad_controller.sv
testbench/touch_adc_model.sv
testbench/touchpad_controller_tb.sv
